// ==== hw/int_mem_pkg.sv ====
package int_mem_pkg;

   // bus widths
   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;

   // memory map
   localparam int SRAM_ADDR_W = 12;
   localparam int BOOTROM_ADDR_W = 6;
   localparam int B_BIT = 12;
   localparam int SRAM_WORDS = 2 ** (SRAM_ADDR_W - 2);
   localparam int BOOTROM_WORDS = 2 ** (BOOTROM_ADDR_W - 2);

   // boot code sits in the last BOOTROM bytes of the sram
   localparam logic [ADDR_W-1:0] BOOT_OFFSET =
      ADDR_W'(2 ** SRAM_ADDR_W - 2 ** BOOTROM_ADDR_W);

   localparam BOOT_HEXFILE = "boot.hex";

   // master to slave, write when any strobe is set
   typedef struct packed {
      logic              avalid;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [STRB_W-1:0] wstrb;
   } iob_req_t;

   // slave to master
   typedef struct packed {
      logic [DATA_W-1:0] rdata;
      logic              rvalid;
      logic              ready;
   } iob_resp_t;

   // moves an address into the boot region, wrapping inside the sram
   function automatic logic [ADDR_W-1:0] rebase(input logic [ADDR_W-1:0] addr,
                                                input logic boot);
      logic [SRAM_ADDR_W-1:0] low;
      low = addr[SRAM_ADDR_W-1:0] + BOOT_OFFSET[SRAM_ADDR_W-1:0];
      if (boot) begin
         return {addr[ADDR_W-1:SRAM_ADDR_W], low};
      end
      return addr;
   endfunction

endpackage

// ==== hw/dp_sram.sv ====
`timescale 1ns/1ps

module dp_sram import int_mem_pkg::*; (
   input  logic      clk_i,

   // port 0
   input  iob_req_t  i_req_i,
   output iob_resp_t i_resp_o,

   // port 1
   input  iob_req_t  d_req_i,
   output iob_resp_t d_resp_o
);

   localparam int IDX_W = SRAM_ADDR_W - 2;

   logic [DATA_W-1:0] mem [SRAM_WORDS];

   iob_req_t  req [2];
   iob_resp_t resp [2];

   assign req[0] = i_req_i;
   assign req[1] = d_req_i;
   assign i_resp_o = resp[0];
   assign d_resp_o = resp[1];

   // same logic for both ports, sharing one array
   for (genvar p = 0; p < 2; p++) begin : g_port
      logic [IDX_W-1:0]  idx;
      logic [DATA_W-1:0] rdata_q;
      logic              rvalid_q;

      assign idx = req[p].addr[SRAM_ADDR_W-1:2];

      always @(posedge clk_i) begin
         if (req[p].avalid) begin
            for (int b = 0; b < STRB_W; b++) begin
               if (req[p].wstrb[b]) begin
                  mem[idx][8*b +: 8] <= req[p].wdata[8*b +: 8];
               end
            end
            // old data on a write, rvalid stays low anyway
            rdata_q <= mem[idx];
         end
         rvalid_q <= req[p].avalid & ~|req[p].wstrb;
      end

      always_comb begin
         resp[p].rdata = rdata_q;
         resp[p].rvalid = rvalid_q;
         resp[p].ready = 1'b1;
      end
   end

endmodule

// ==== hw/bus_split.sv ====
`timescale 1ns/1ps

module bus_split import int_mem_pkg::*; (
   input  logic      clk_i,
   input  logic      rst_i,

   input  iob_req_t  m_req_i,
   output iob_resp_t m_resp_o,

   output iob_req_t  s0_req_o,
   input  iob_resp_t s0_resp_i,
   output iob_req_t  s1_req_o,
   input  iob_resp_t s1_resp_i
);

   logic sel;
   logic sel_q;
   logic m_ready;

   assign sel = m_req_i.addr[B_BIT];
   assign m_ready = sel ? s1_resp_i.ready : s0_resp_i.ready;

   // both slaves see the payload, only one sees avalid
   always_comb begin
      s0_req_o = m_req_i;
      s1_req_o = m_req_i;
      s0_req_o.avalid = m_req_i.avalid & ~sel;
      s1_req_o.avalid = m_req_i.avalid & sel;
   end

   // remember who took the request for the response cycle
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         sel_q <= 1'b0;
      end else if (m_req_i.avalid && m_ready) begin
         sel_q <= sel;
      end
   end

   always_comb begin
      m_resp_o.ready = m_ready;
      m_resp_o.rdata = sel_q ? s1_resp_i.rdata : s0_resp_i.rdata;
      m_resp_o.rvalid = sel_q ? s1_resp_i.rvalid : s0_resp_i.rvalid;
   end

endmodule

// ==== hw/bus_merge.sv ====
`timescale 1ns/1ps

module bus_merge import int_mem_pkg::*; (
   input  logic      clk_i,
   input  logic      rst_i,

   // m0 wins whenever it is valid
   input  iob_req_t  m0_req_i,
   output iob_resp_t m0_resp_o,
   input  iob_req_t  m1_req_i,
   output iob_resp_t m1_resp_o,

   output iob_req_t  s_req_o,
   input  iob_resp_t s_resp_i
);

   logic gnt1;
   logic gnt1_q;
   logic accept;

   assign gnt1 = ~m0_req_i.avalid;
   assign accept = s_req_o.avalid & s_resp_i.ready;

   always_comb begin
      s_req_o = gnt1 ? m1_req_i : m0_req_i;
   end

   // owner of the response in the next cycle
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         gnt1_q <= 1'b0;
      end else if (accept) begin
         gnt1_q <= gnt1;
      end
   end

   // rdata is shared, rvalid goes only to the owner
   always_comb begin
      m0_resp_o.rdata = s_resp_i.rdata;
      m0_resp_o.rvalid = s_resp_i.rvalid & ~gnt1_q;
      m0_resp_o.ready = s_resp_i.ready;

      m1_resp_o.rdata = s_resp_i.rdata;
      m1_resp_o.rvalid = s_resp_i.rvalid & gnt1_q;
      // held off while m0 is using the slave
      m1_resp_o.ready = s_resp_i.ready & gnt1;
   end

endmodule

// ==== hw/boot_ctr.sv ====
`timescale 1ns/1ps

module boot_ctr import int_mem_pkg::*; (
   input  logic      clk_i,
   input  logic      rst_i,

   // single-address control register
   input  iob_req_t  cpu_req_i,
   output iob_resp_t cpu_resp_o,

   // write master into the sram
   output iob_req_t  sram_req_o,
   input  iob_resp_t sram_resp_i,

   output logic      boot_o,
   output logic      cpu_reset_o
);

   localparam int CNT_W = BOOTROM_ADDR_W - 2;

   logic [DATA_W-1:0] rom [BOOTROM_WORDS];

   // copy sequencer
   logic [CNT_W-1:0]  cnt_q;
   logic              copy_q;
   logic              done_q;
   logic              wr_ack;
   logic              last_wr;

   // control register
   logic              reg_rd;
   logic              reg_wr;
   logic              boot_q;
   logic              cpu_reset_q;
   logic              rvalid_q;
   logic [DATA_W-1:0] rdata_q;

   initial begin
      $readmemh(BOOT_HEXFILE, rom);
   end

   assign wr_ack = copy_q & sram_resp_i.ready;
   assign last_wr = wr_ack & (cnt_q == CNT_W'(BOOTROM_WORDS - 1));

   // one word per accepted write, starting the cycle after reset
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         copy_q <= 1'b0;
         done_q <= 1'b0;
         cnt_q <= '0;
      end else if (!copy_q && !done_q) begin
         copy_q <= 1'b1;
      end else if (wr_ack) begin
         cnt_q <= cnt_q + 1'b1;
         if (last_wr) begin
            copy_q <= 1'b0;
            done_q <= 1'b1;
         end
      end
   end

   // word k lands at BOOT_OFFSET + 4k
   always_comb begin
      sram_req_o.avalid = copy_q;
      sram_req_o.addr = BOOT_OFFSET + {{(ADDR_W-CNT_W-2){1'b0}}, cnt_q, 2'b00};
      sram_req_o.wdata = rom[cnt_q];
      sram_req_o.wstrb = '1;
   end

   assign reg_rd = cpu_req_i.avalid & ~|cpu_req_i.wstrb;
   assign reg_wr = cpu_req_i.avalid & |cpu_req_i.wstrb;

   // bit 0 is the boot flag, bit 1 requests a cpu reset pulse
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         boot_q <= 1'b1;
         cpu_reset_q <= 1'b1;
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= reg_rd;
         if (reg_wr) begin
            boot_q <= cpu_req_i.wdata[0];
         end
         if (reg_wr && cpu_req_i.wdata[1]) begin
            cpu_reset_q <= 1'b1;
         end else if (last_wr || done_q) begin
            // released once the last word is in
            cpu_reset_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (reg_rd) begin
         rdata_q <= {{(DATA_W-1){1'b0}}, boot_q};
      end
   end

   always_comb begin
      cpu_resp_o.rdata = rdata_q;
      cpu_resp_o.rvalid = rvalid_q;
      cpu_resp_o.ready = 1'b1;
   end

   assign boot_o = boot_q;
   assign cpu_reset_o = cpu_reset_q;

endmodule

// ==== hw/int_mem.sv ====
`timescale 1ns/1ps

module int_mem import int_mem_pkg::*; (
   input  logic      clk_i,
   input  logic      rst_i,

   // instruction bus
   input  iob_req_t  i_req_i,
   output iob_resp_t i_resp_o,

   // data bus
   input  iob_req_t  d_req_i,
   output iob_resp_t d_resp_o,

   output logic      boot_o,
   output logic      cpu_reset_o
);

   // data bus, sram side of the split
   iob_req_t  ram_d_req;
   iob_resp_t ram_d_resp;

   // data bus, boot controller side
   iob_req_t  ctr_req;
   iob_resp_t ctr_resp;

   // sram data port after rebase
   iob_req_t  ram_d_req_rb;

   // copier writes into the sram
   iob_req_t  boot_w_req;
   iob_resp_t boot_w_resp;

   // instruction reads after rebase
   iob_req_t  ram_r_req;

   // merged sram instruction port
   iob_req_t  ram_i_req;
   iob_resp_t ram_i_resp;

   bus_split u_split (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .m_req_i   (d_req_i),
      .m_resp_o  (d_resp_o),
      .s0_req_o  (ram_d_req),
      .s0_resp_i (ram_d_resp),
      .s1_req_o  (ctr_req),
      .s1_resp_i (ctr_resp)
   );

   boot_ctr u_boot_ctr (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .cpu_req_i   (ctr_req),
      .cpu_resp_o  (ctr_resp),
      .sram_req_o  (boot_w_req),
      .sram_resp_i (boot_w_resp),
      .boot_o      (boot_o),
      .cpu_reset_o (cpu_reset_o)
   );

   // boot code is linked at 0 but runs from the top of the sram
   always_comb begin
      ram_r_req = i_req_i;
      ram_r_req.addr = rebase(i_req_i.addr, boot_o);
   end

   always_comb begin
      ram_d_req_rb = ram_d_req;
      ram_d_req_rb.addr = rebase(ram_d_req.addr, boot_o);
   end

   // copier outranks the cpu fetch
   bus_merge u_merge (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .m0_req_i  (boot_w_req),
      .m0_resp_o (boot_w_resp),
      .m1_req_i  (ram_r_req),
      .m1_resp_o (i_resp_o),
      .s_req_o   (ram_i_req),
      .s_resp_i  (ram_i_resp)
   );

   dp_sram u_sram (
      .clk_i    (clk_i),
      .i_req_i  (ram_i_req),
      .i_resp_o (ram_i_resp),
      .d_req_i  (ram_d_req_rb),
      .d_resp_o (ram_d_resp)
   );

endmodule

// ==== test/int_mem_tb.sv ====
`timescale 1ns/1ps

module int_mem_tb import int_mem_pkg::*; ();

   localparam int CLK_PERIOD = 4;
   localparam int RESET_CYCLES = 10;
   localparam int COPY_CYCLES = 17;
   localparam int N_RAND = 32;
   localparam int RUN_CYCLES =
      RESET_CYCLES + COPY_CYCLES + 2 * BOOTROM_WORDS + 8 * N_RAND + 20;
   localparam int BOOT_WORD = int'(BOOT_OFFSET) / 4;
   localparam logic [ADDR_W-1:0] CTRL_ADDR = 1 << B_BIT;

   logic      clk_i;
   logic      rst_i;
   iob_req_t  i_req_i;
   iob_resp_t i_resp_o;
   iob_req_t  d_req_i;
   iob_resp_t d_resp_o;
   logic      boot_o;
   logic      cpu_reset_o;

   logic [DATA_W-1:0] boot_img [BOOTROM_WORDS];
   logic [DATA_W-1:0] ref_mem [SRAM_WORDS];
   logic [ADDR_W-1:0] wr_addrs [$];
   int data_errs = 0;
   int ctrl_errs = 0;

   // expected state kept by the monitor
   int                rel_cycles;
   logic              exp_boot;
   logic              exp_cpu_reset;
   logic              i_pend;
   logic              d_pend;
   logic [DATA_W-1:0] i_exp;
   logic [DATA_W-1:0] d_exp;

   int_mem uut (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .i_req_i     (i_req_i),
      .i_resp_o    (i_resp_o),
      .d_req_i     (d_req_i),
      .d_resp_o    (d_resp_o),
      .boot_o      (boot_o),
      .cpu_reset_o (cpu_reset_o)
   );

   initial clk_i = 1'b0;
   always #(CLK_PERIOD / 2) clk_i = ~clk_i;

   // sram word that a cpu address lands on
   // boot code is linked at 0
   function automatic int sram_word(input logic [ADDR_W-1:0] addr, input logic boot);
      logic [SRAM_ADDR_W-1:0] byte_addr;
      byte_addr = addr[SRAM_ADDR_W-1:0];
      if (boot) begin
         byte_addr = byte_addr + BOOT_OFFSET[SRAM_ADDR_W-1:0];
      end
      return int'(byte_addr >> 2);
   endfunction

   task automatic expect_eq(input string name, input logic [DATA_W-1:0] exp,
                            input logic [DATA_W-1:0] got, input bit ctrl);
      assert (got === exp) else begin
         if (ctrl) begin
            ctrl_errs++;
         end else begin
            data_errs++;
         end
         $display("error at %0t ns: %s expected %h got %h", $time, name, exp, got);
      end
   endtask

   always @(posedge clk_i) begin : monitor
      int   w;
      logic reg_wr;
      logic copying;
      logic [DATA_W-1:0] reg_wdata;
      reg_wr = 1'b0;
      reg_wdata = '0;
      copying = rel_cycles >= 1 && rel_cycles <= BOOTROM_WORDS;
      if (rst_i) begin
         rel_cycles = 0;
         exp_boot = 1'b1;
         exp_cpu_reset = 1'b1;
         i_pend = 1'b0;
         d_pend = 1'b0;
      end else begin
         expect_eq("boot_o", DATA_W'(exp_boot), DATA_W'(boot_o), 1'b1);
         expect_eq("cpu_reset_o", DATA_W'(exp_cpu_reset), DATA_W'(cpu_reset_o), 1'b1);
         // copier owns the instruction port
         expect_eq("i_resp_o.ready", DATA_W'(!copying), DATA_W'(i_resp_o.ready), 1'b1);
         expect_eq("d_resp_o.ready", DATA_W'(1'b1), DATA_W'(d_resp_o.ready), 1'b1);
         expect_eq("i_resp_o.rvalid", DATA_W'(i_pend), DATA_W'(i_resp_o.rvalid), 1'b1);
         if (i_pend) begin
            expect_eq("i_resp_o.rdata", i_exp, i_resp_o.rdata, 1'b0);
         end
         expect_eq("d_resp_o.rvalid", DATA_W'(d_pend), DATA_W'(d_resp_o.rvalid), 1'b1);
         if (d_pend) begin
            expect_eq("d_resp_o.rdata", d_exp, d_resp_o.rdata, 1'b0);
         end

         // reads see memory from before this edge
         i_pend = i_req_i.avalid && i_resp_o.ready && i_req_i.wstrb == '0;
         if (i_pend) begin
            i_exp = ref_mem[sram_word(i_req_i.addr, exp_boot)];
         end
         d_pend = 1'b0;
         if (d_req_i.avalid && d_resp_o.ready) begin
            if (d_req_i.addr[B_BIT]) begin
               if (d_req_i.wstrb == '0) begin
                  d_pend = 1'b1;
                  d_exp = DATA_W'(exp_boot);
               end else begin
                  reg_wr = 1'b1;
                  reg_wdata = d_req_i.wdata;
               end
            end else begin
               w = sram_word(d_req_i.addr, exp_boot);
               if (d_req_i.wstrb == '0) begin
                  d_pend = 1'b1;
                  d_exp = ref_mem[w];
               end else begin
                  for (int b = 0; b < STRB_W; b++) begin
                     if (d_req_i.wstrb[b]) begin
                        ref_mem[w][8*b +: 8] = d_req_i.wdata[8*b +: 8];
                     end
                  end
               end
            end
         end

         // rom word k is written at edge k+1 after release
         if (copying) begin
            ref_mem[BOOT_WORD + rel_cycles - 1] = boot_img[rel_cycles - 1];
         end

         if (reg_wr) begin
            exp_boot = reg_wdata[0];
         end
         if (reg_wr && reg_wdata[1]) begin
            exp_cpu_reset = 1'b1;
         end else if (rel_cycles >= COPY_CYCLES - 1) begin
            exp_cpu_reset = 1'b0;
         end
         rel_cycles++;
      end
   end

   task automatic fetch(input logic [ADDR_W-1:0] addr);
      i_req_i = '{avalid: 1'b1, addr: addr, wdata: '0, wstrb: '0};
      @(posedge clk_i);
      while (!i_resp_o.ready) begin
         @(posedge clk_i);
      end
      #1;
      i_req_i = '0;
   endtask

   task automatic data_access(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                              input logic [STRB_W-1:0] wstrb);
      d_req_i = '{avalid: 1'b1, addr: addr, wdata: wdata, wstrb: wstrb};
      @(posedge clk_i);
      while (!d_resp_o.ready) begin
         @(posedge clk_i);
      end
      #1;
      d_req_i = '0;
   endtask

   // full word first, then a partial overwrite
   task automatic write_random(input int count);
      logic [ADDR_W-1:0] addr;
      for (int n = 0; n < count; n++) begin
         addr = ADDR_W'($urandom_range(SRAM_WORDS - BOOTROM_WORDS - 1, BOOTROM_WORDS)) << 2;
         data_access(addr, $urandom, '1);
         data_access(addr, $urandom, STRB_W'($urandom_range(2 ** STRB_W - 1, 1)));
         wr_addrs.push_back(addr);
      end
   endtask

   task automatic read_back();
      foreach (wr_addrs[n]) begin
         data_access(wr_addrs[n], '0, '0);
         fetch(wr_addrs[n]);
      end
      wr_addrs.delete();
   endtask

   initial begin : stimulus
      void'($urandom(38553));
      rst_i = 1'b1;
      i_req_i = '0;
      d_req_i = '0;
      $readmemh("test/boot.hex", boot_img);
      #1;
      // dut rom gets the same image
      $readmemh("test/boot.hex", uut.u_boot_ctr.rom);
      repeat (RESET_CYCLES) @(posedge clk_i);
      #1;
      rst_i = 1'b0;

      // first fetch waits out the copy
      @(posedge clk_i);
      #1;
      for (int k = 0; k < BOOTROM_WORDS; k++) begin
         fetch(ADDR_W'(4 * k));
      end
      data_access(CTRL_ADDR, '0, '0);
      write_random(N_RAND);
      read_back();

      // leave boot mode so boot code sits at its physical place
      data_access(CTRL_ADDR, '0, '1);
      for (int k = 0; k < BOOTROM_WORDS; k++) begin
         fetch(BOOT_OFFSET + ADDR_W'(4 * k));
      end
      data_access(CTRL_ADDR, '0, '0);

      // cpu reset pulse
      data_access(CTRL_ADDR, 32'h2, '1);
      write_random(N_RAND);
      read_back();
      repeat (4) @(posedge clk_i);

      $display("errors: %0d data, %0d control", data_errs, ctrl_errs);
      if (data_errs == 0 && ctrl_errs == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

   initial begin : watchdog
      #(CLK_PERIOD * (RUN_CYCLES + 200));
      $display("timeout: run did not finish within %0d cycles", RUN_CYCLES + 200);
      $display("Verification failed");
      $finish;
   end

endmodule

// ==== test/boot.hex ====
// boot rom image, one 32-bit word per line in hex, word 0 first
00001137
10010113
00000093
00100193
00112023
00312223
00410113
fff18193
fe019ae3
000010b7
00200113
0020a023
13579bdf
2468ace0
a5a55a5a
0000006f

// ==== list.f ====
hw/int_mem_pkg.sv
hw/dp_sram.sv
hw/bus_split.sv
hw/bus_merge.sv
hw/boot_ctr.sv
hw/int_mem.sv
test/int_mem_tb.sv
